// ==== logic/procPkg.sv ====
//##################################################
// Processor package
// Widths, select encodings, FSM states and the
// synchronized button bundle used across the design
//##################################################

package procPkg;

    localparam int dataWidth  = 8;  // Register and Din width
    localparam int shiftCount = 8;  // Shifts per Execute press

    // Bitwise function on the bit pair, from the F switches
    typedef enum logic [2:0] {
        opAnd   = 3'b000,
        opOr    = 3'b001,
        opXor   = 3'b010,
        opOnes  = 3'b011,  // Constant 1
        opNand  = 3'b100,
        opNor   = 3'b101,
        opXnor  = 3'b110,
        opZeros = 3'b111   // Constant 0
    } funcSel;

    // Feedback routing, from the R switches
    typedef enum logic [1:0] {
        rtKeep = 2'b00,  // A gets A, B gets B
        rtToB  = 2'b01,  // B gets the result
        rtToA  = 2'b10,  // A gets the result
        rtSwap = 2'b11   // A and B trade bits
    } routeSel;

    typedef enum logic [1:0] {
        stIdle  = 2'b00,
        stShift = 2'b01,
        stHold  = 2'b10  // Wait for Execute release
    } ctrlState;

    // Synced buttons, active high
    typedef struct packed {
        logic loadA;
        logic loadB;
        logic execute;
    } syncBtns;

endpackage

// ==== logic/inputSync.sv ====
//##################################################
// Input synchronizer
// Two flops on every switch and button, buttons
// inverted to active high
//##################################################

module inputSync (
    input  logic                          Clk,
    input  logic                          rstN,
    input  logic                          loadAN,    // Active-low push buttons
    input  logic                          loadBN,
    input  logic                          executeN,
    input  logic [procPkg::dataWidth-1:0] din,       // Data switches
    input  logic [2:0]                    f,         // Function switches
    input  logic [1:0]                    r,         // Route switches
    output procPkg::syncBtns              btns,
    output logic [procPkg::dataWidth-1:0] dinS,
    output procPkg::funcSel               fS,
    output procPkg::routeSel              rS
);
    import procPkg::*;

    // All asynchronous inputs as one bundle
    typedef struct packed {
        syncBtns              btns;
        logic [dataWidth-1:0] din;
        funcSel               f;
        routeSel              r;
    } syncBus;

    syncBus rawBus;     // Straight off the pins
    syncBus metaBus;    // First stage, may be metastable
    syncBus stableBus;  // Second stage

    // Pressed button pulls low, flip so pressed reads 1
    assign rawBus.btns.loadA   = ~loadAN;
    assign rawBus.btns.loadB   = ~loadBN;
    assign rawBus.btns.execute = ~executeN;
    assign rawBus.din          = din;
    assign rawBus.f            = funcSel'(f);   // Switch code to enum
    assign rawBus.r            = routeSel'(r);

    always_ff @(posedge Clk or negedge rstN) begin
        if (!rstN) begin
            metaBus   <= '0;  // Buttons read as released
            stableBus <= '0;
        end else begin
            metaBus   <= rawBus;
            stableBus <= metaBus;
        end
    end

    assign btns = stableBus.btns;
    assign dinS = stableBus.din;
    assign fS   = stableBus.f;
    assign rS   = stableBus.r;

endmodule

// ==== logic/shiftRegPair.sv ====
//##################################################
// Register pair A and B
// Parallel load from Din, joint right shift with
// serial bits entering at the MSBs
//##################################################

module shiftRegPair (
    input  logic                          Clk,
    input  logic                          rstN,
    input  logic                          ldA,      // Load d into A
    input  logic                          ldB,      // Load d into B
    input  logic                          shiftEn,  // Shift both right by one
    input  logic [procPkg::dataWidth-1:0] d,
    input  logic                          inA,      // Serial in at A MSB
    input  logic                          inB,      // Serial in at B MSB
    output logic                          outA,     // Current A LSB
    output logic                          outB,     // Current B LSB
    output logic [procPkg::dataWidth-1:0] regA,
    output logic [procPkg::dataWidth-1:0] regB
);
    import procPkg::*;

    // Register A
    always_ff @(posedge Clk or negedge rstN) begin
        if (!rstN) begin
            regA <= '0;
        end else if (ldA) begin  // Load wins over shift
            regA <= d;
        end else if (shiftEn) begin
            regA <= {inA, regA[dataWidth-1:1]};
        end
    end

    // Register B, same rules
    always_ff @(posedge Clk or negedge rstN) begin
        if (!rstN) begin
            regB <= '0;
        end else if (ldB) begin
            regB <= d;
        end else if (shiftEn) begin
            regB <= {inB, regB[dataWidth-1:1]};
        end
    end

    // LSBs feed the serial datapath
    assign outA = regA[0];
    assign outB = regB[0];

endmodule

// ==== logic/bitCompute.sv ====
//##################################################
// Bit compute unit
// One of eight bitwise functions on the outgoing
// LSB pair, operands passed on for recirculation
//##################################################

module bitCompute (
    input  procPkg::funcSel f,
    input  logic            inA,   // A LSB
    input  logic            inB,   // B LSB
    output logic            outA,
    output logic            outB,
    output logic            fab    // f(A, B)
);
    import procPkg::*;

    // Operands go through untouched for the router
    assign outA = inA;
    assign outB = inB;

    always_comb begin
        case (f)
            opAnd:   fab = inA & inB;
            opOr:    fab = inA | inB;
            opXor:   fab = inA ^ inB;
            opOnes:  fab = 1'b1;
            opNand:  fab = ~(inA & inB);
            opNor:   fab = ~(inA | inB);
            opXnor:  fab = ~(inA ^ inB);
            opZeros: fab = 1'b0;
            default: fab = 1'b0;
        endcase
    end

endmodule

// ==== logic/bitRouter.sv ====
//##################################################
// Bit router
// Picks the bits shifted back into A and B
//##################################################

module bitRouter (
    input  procPkg::routeSel r,
    input  logic             inA,   // Original A bit
    input  logic             inB,   // Original B bit
    input  logic             fab,   // Function result
    output logic             outA,  // Next A MSB
    output logic             outB   // Next B MSB
);
    import procPkg::*;

    // Eight passes rebuild each register whole
    always_comb begin
        case (r)
            rtKeep: begin
                outA = inA;  // Both recirculate
                outB = inB;
            end
            rtToB: begin
                outA = inA;
                outB = fab;
            end
            rtToA: begin
                outA = fab;
                outB = inB;
            end
            rtSwap: begin
                outA = inB;
                outB = inA;
            end
            default: begin
                outA = inA;
                outB = inB;
            end
        endcase
    end

endmodule

// ==== logic/procControl.sv ====
//##################################################
// Processor control FSM
// Load strobes in idle, eight shifts per Execute,
// then a hold until Execute is released
//##################################################

module procControl (
    input  logic             Clk,
    input  logic             rstN,
    input  procPkg::syncBtns btns,     // Synced button levels
    output logic             ldA,
    output logic             ldB,
    output logic             shiftEn
);
    import procPkg::*;

    ctrlState state;
    ctrlState stateNext;

    logic [$clog2(shiftCount)-1:0] shiftCnt;  // Shifts done in this run
    logic                          lastShift;

    assign lastShift = (int'(shiftCnt) == shiftCount - 1);

    // State register
    always_ff @(posedge Clk or negedge rstN) begin
        if (!rstN) begin
            state <= stIdle;
        end else begin
            state <= stateNext;
        end
    end

    // Shift counter, cleared whenever not shifting
    always_ff @(posedge Clk or negedge rstN) begin
        if (!rstN) begin
            shiftCnt <= '0;
        end else if (state == stShift) begin
            shiftCnt <= shiftCnt + 1'b1;
        end else begin
            shiftCnt <= '0;
        end
    end

    always_comb begin
        stateNext = state;
        case (state)
            stIdle: begin
                if (btns.execute) begin
                    stateNext = stShift;
                end
            end
            stShift: begin
                if (lastShift) begin  // Eighth shift this cycle
                    stateNext = stHold;
                end
            end
            stHold: begin
                // Held button must not start a second run
                if (!btns.execute) begin
                    stateNext = stIdle;
                end
            end
            default: stateNext = stIdle;
        endcase
    end

    // Loads only while idle, repeats harmlessly if held
    assign ldA     = (state == stIdle) && btns.loadA;
    assign ldB     = (state == stIdle) && btns.loadB;
    assign shiftEn = (state == stShift);

endmodule

// ==== logic/hexDigit.sv ====
//##################################################
// Hex digit decoder
// Nibble to active-low segments, seg[0] is a
//##################################################

module hexDigit (
    input  logic [3:0] nibble,
    output logic [6:0] seg      // {g, f, e, d, c, b, a}, low is lit
);

    always_comb begin
        unique case (nibble)
            4'h0: seg = 7'b1000000;
            4'h1: seg = 7'b1111001;
            4'h2: seg = 7'b0100100;
            4'h3: seg = 7'b0110000;
            4'h4: seg = 7'b0011001;
            4'h5: seg = 7'b0010010;
            4'h6: seg = 7'b0000010;
            4'h7: seg = 7'b1111000;
            4'h8: seg = 7'b0000000;  // All on
            4'h9: seg = 7'b0010000;
            4'hA: seg = 7'b0001000;
            4'hB: seg = 7'b0000011;  // Lower case b
            4'hC: seg = 7'b1000110;
            4'hD: seg = 7'b0100001;  // Lower case d
            4'hE: seg = 7'b0000110;
            4'hF: seg = 7'b0001110;
        endcase
    end

endmodule

// ==== logic/processor.sv ====
//##################################################
// Bit-serial logic processor, top level
// Synced inputs, control FSM, register pair, serial
// compute and route path, hex display decoders
//##################################################

module processor (
    input  logic                          Clk,
    input  logic                          rstN,
    input  logic                          LoadA,    // Push buttons, active low
    input  logic                          LoadB,
    input  logic                          Execute,
    input  logic [procPkg::dataWidth-1:0] Din,      // Operand switches
    input  logic [2:0]                    F,        // Function select
    input  logic [1:0]                    R,        // Routing select
    output logic [2:0]                    LED,      // Debug, synced buttons
    output logic [procPkg::dataWidth-1:0] Aval,     // Debug, register A
    output logic [procPkg::dataWidth-1:0] Bval,     // Debug, register B
    output logic [6:0]                    AhexL,
    output logic [6:0]                    AhexU,
    output logic [6:0]                    BhexL,
    output logic [6:0]                    BhexU
);
    import procPkg::*;

    syncBtns              btns;
    logic [dataWidth-1:0] dinS;
    funcSel               fS;
    routeSel              rS;

    logic                 ldA, ldB, shiftEn;
    logic [dataWidth-1:0] regA, regB;
    logic                 opA, opB;    // Outgoing LSBs
    logic                 bitA, bitB;  // Operands after compute
    logic                 fab;
    logic                 newA, newB;  // Bits into the MSBs

    logic [3:0][3:0]      nibbles;     // {BU, BL, AU, AL}
    logic [3:0][6:0]      segs;

    assign LED  = btns;
    assign Aval = regA;
    assign Bval = regB;

    inputSync inputSync_i (
        .Clk, .rstN,
        .loadAN(LoadA), .loadBN(LoadB), .executeN(Execute),
        .din(Din), .f(F), .r(R),
        .btns, .dinS, .fS, .rS
    );

    procControl procControl_i (.Clk, .rstN, .btns, .ldA, .ldB, .shiftEn);

    shiftRegPair shiftRegPair_i (
        .Clk, .rstN, .ldA, .ldB, .shiftEn,
        .d(dinS), .inA(newA), .inB(newB),
        .outA(opA), .outB(opB), .regA, .regB
    );

    bitCompute bitCompute_i (
        .f(fS), .inA(opA), .inB(opB), .outA(bitA), .outB(bitB), .fab
    );

    bitRouter bitRouter_i (
        .r(rS), .inA(bitA), .inB(bitB), .fab, .outA(newA), .outB(newB)
    );

    // One decoder per nibble of A and B
    assign nibbles = {regB, regA};

    for (genvar i = 0; i < 4; i++) begin : gHex
        hexDigit hexDigit_i (.nibble(nibbles[i]), .seg(segs[i]));
    end

    assign AhexL = segs[0];
    assign AhexU = segs[1];
    assign BhexL = segs[2];
    assign BhexU = segs[3];

endmodule

// ==== verif/processor_properties.sv ====
//##################################################
// Control assertions
// Shift run length, entry point of shift runs and
// the hold on a held Execute in the control FSM
//##################################################

module processor_properties (
    input logic              Clk,
    input logic              rstN,
    input procPkg::syncBtns  btns,      // Synced button levels
    input logic              shiftEn,
    input procPkg::ctrlState state    // FSM state inside procControl
);
    timeunit 1ns;
    timeprecision 100ps;
    import procPkg::*;

    // A held Execute keeps the FSM parked after its run
    holdWhilePressed: assert property (@(posedge Clk) disable iff (!rstN)
        (state == stHold) && btns.execute |=> (state == stHold) && !shiftEn)
        else $error("FSM left stHold while Execute was still held");

    // Exactly shiftCount shifts, then a gap
    shiftRunLength: assert property (@(posedge Clk) disable iff (!rstN)
        $rose(shiftEn) |-> shiftEn [*shiftCount] ##1 !shiftEn)
        else $error("shiftEn run was not %0d cycles long", shiftCount);

    // A run only starts on the idle to shift step
    shiftStartsFromIdle: assert property (@(posedge Clk) disable iff (!rstN)
        $rose(shiftEn) |-> (state == stShift) && ($past(state) == stIdle))
        else $error("shiftEn rose outside the stIdle to stShift step");

endmodule

bind procControl processor_properties props_i (
    .Clk, .rstN, .btns, .shiftEn, .state
);

// ==== verif/processorTb.sv ====
//##################################################
// Processor testbench
// Loads operands, runs Execute per vector from the
// vector file, checks registers and hex digits
//##################################################

module processorTb;
    timeunit 1ns;
    timeprecision 100ps;
    import procPkg::*;

    localparam string vectorFile = "verif/processor_vectors.txt";
    localparam int    pressCycles = 4;   // Normal button press
    localparam int    longPress   = 14;  // Outlasts the whole shift run
    localparam int    settleWait  = 16;  // After Execute release

    // Lit segments {g..a}, active high, digits 0 to F
    localparam logic [6:0] litSegs [16] = '{7'h3F, 7'h06, 7'h5B, 7'h4F, 7'h66, 7'h6D,
        7'h7D, 7'h07, 7'h7F, 7'h6F, 7'h77, 7'h7C, 7'h39, 7'h5E, 7'h79, 7'h71};

    typedef struct packed {
        logic [7:0] dinA;
        logic [7:0] dinB;
        funcSel     f;
        routeSel    r;
        logic [7:0] expA;
        logic [7:0] expB;
    } testVec;

    logic       Clk, rstN;
    logic       LoadA, LoadB, Execute;  // Active low, 1 is released
    logic [7:0] Din;
    logic [2:0] F;
    logic [1:0] R;
    logic [2:0] LED;
    logic [7:0] Aval, Bval;
    logic [6:0] AhexL, AhexU, BhexL, BhexU;

    testVec vecs[$];
    int     errors = 0;
    int     checks = 0;
    int     cycleCnt = 0;
    int     cycleLimit = 100;  // Raised once the vectors are known

    processor processor_i (.*);

    initial begin
        Clk = 1'b0;
        forever #5 Clk = ~Clk;
    end

    // Run limit
    always @(posedge Clk) begin
        cycleCnt = cycleCnt + 1;
        if (cycleCnt >= cycleLimit) begin
            $display("Timeout: run did not end within %0d cycles, %0d errors so far",
                     cycleLimit, errors);
            $display("Finished with errors");
            $finish;
        end
    end

    task automatic checkValue(logic [7:0] got, logic [7:0] exp, string name, string what);
        checks++;
        if (got !== exp) begin
            $display("Fail at %0t: %s, %s is %h, expected %h", $time, what, name, got, exp);
            errors++;
        end
    endtask

    task automatic checkSeg(logic [6:0] seg, logic [3:0] nib, string name, string what);
        checks++;
        if (seg !== ~litSegs[nib]) begin  // Display lights on low
            $display("Fail at %0t: %s, %s is %b, expected %b for digit %h",
                     $time, what, name, seg, ~litSegs[nib], nib);
            errors++;
        end
    endtask

    // Both registers and the four digits that show them
    task automatic checkRegs(logic [7:0] expA, logic [7:0] expB, string what);
        checkValue(Aval, expA, "Aval", what);
        checkValue(Bval, expB, "Bval", what);
        checkSeg(AhexL, expA[3:0], "AhexL", what);
        checkSeg(AhexU, expA[7:4], "AhexU", what);
        checkSeg(BhexL, expB[3:0], "BhexL", what);
        checkSeg(BhexU, expB[7:4], "BhexU", what);
    endtask

    task automatic readVectors();
        int     fd;
        string  line;
        int     dinA, dinB, f, r, expA, expB;
        testVec v;
        fd = $fopen(vectorFile, "r");
        if (fd == 0) begin
            $display("Could not open the vector file %s", vectorFile);
            errors++;
            return;
        end
        while ($fgets(line, fd) != 0) begin
            if (line.len() < 2 || line.getc(0) == "#") begin
                continue;  // Blank or column header
            end
            if ($sscanf(line, "%h %h %d %d %h %h", dinA, dinB, f, r, expA, expB) == 6) begin
                v.dinA = dinA[7:0];
                v.dinB = dinB[7:0];
                v.f    = funcSel'(f[2:0]);
                v.r    = routeSel'(r[1:0]);
                v.expA = expA[7:0];
                v.expB = expB[7:0];
                vecs.push_back(v);
            end
        end
        $fclose(fd);
    endtask

    task automatic idleGap();
        repeat ($urandom % 6) @(posedge Clk);  // 0 to 5 cycles
    endtask

    // Press LoadA or LoadB with value on Din, then release
    task automatic loadOperand(logic toB, logic [7:0] value);
        @(posedge Clk);
        if (toB) begin
            LoadB <= 1'b0;
        end else begin
            LoadA <= 1'b0;
        end
        Din <= value;  // Held until the next load
        repeat (pressCycles) @(posedge Clk);
        LoadA <= 1'b1;
        LoadB <= 1'b1;
        @(negedge Clk);
        // LED is {loadA, loadB, execute}, press still in the synchronizer
        checkValue({5'b0, LED}, toB ? 8'h02 : 8'h04, "LED", "load button pressed");
    endtask

    task automatic runExecute(funcSel f, routeSel r, int hold);
        @(posedge Clk);
        Execute <= 1'b0;
        F       <= f;
        R       <= r;
        repeat (hold) @(posedge Clk);
        Execute <= 1'b1;
        @(negedge Clk);
        checkValue({5'b0, LED}, 8'h01, "LED", "Execute pressed");
        repeat (settleWait) @(posedge Clk);  // Result is final 11 cycles after the press
        @(negedge Clk);
        checkValue({5'b0, LED}, 8'h00, "LED", "Execute released");
    endtask

    initial begin
        logic [7:0] curA;
        logic [7:0] curB;
        testVec     v;
        int         hold;
        void'($urandom(7628));
        rstN    = 1'b0;
        LoadA   = 1'b1;
        LoadB   = 1'b1;
        Execute = 1'b1;
        Din     = '0;
        F       = '0;
        R       = '0;
        readVectors();
        if (vecs.size() == 0) begin
            $display("No test vectors were read");
            errors++;
        end
        cycleLimit = vecs.size() * 60 + 100;
        repeat (10) @(posedge Clk);
        rstN <= 1'b1;
        @(negedge Clk);
        checkRegs(8'h00, 8'h00, "after reset");
        checkValue({5'b0, LED}, 8'h00, "LED", "after reset");
        curA = '0;
        curB = '0;
        foreach (vecs[i]) begin
            v = vecs[i];
            hold = (i % 3 == 2) ? longPress : pressCycles;  // Every third press held long
            loadOperand(1'b0, v.dinA);
            checkRegs(v.dinA, curB, $sformatf("vector %0d load A", i));
            curA = v.dinA;
            idleGap();
            loadOperand(1'b1, v.dinB);
            checkRegs(curA, v.dinB, $sformatf("vector %0d load B", i));
            curB = v.dinB;
            idleGap();
            runExecute(v.f, v.r, hold);
            checkRegs(v.expA, v.expB,
                      $sformatf("vector %0d execute %s %s", i, v.f.name(), v.r.name()));
            curA = v.expA;
            curB = v.expB;
            idleGap();
        end
        $display("Errors: %0d in %0d checks over %0d vectors", errors, checks, vecs.size());
        if (errors == 0) begin
            $display("Finished with no errors");
        end else begin
            $display("Finished with errors");
        end
        $finish;
    end

endmodule

// ==== vlog.f ====
logic/procPkg.sv
logic/inputSync.sv
logic/shiftRegPair.sv
logic/bitCompute.sv
logic/bitRouter.sv
logic/procControl.sv
logic/hexDigit.sv
logic/processor.sv
verif/processor_properties.sv
verif/processorTb.sv

// ==== Bender.yml ====
package:
  name: processor

sources:
  - logic/procPkg.sv
  - logic/inputSync.sv
  - logic/shiftRegPair.sv
  - logic/bitCompute.sv
  - logic/bitRouter.sv
  - logic/procControl.sv
  - logic/hexDigit.sv
  - logic/processor.sv
  - target: simulation
    files:
      - verif/processor_properties.sv
      - verif/processorTb.sv

// ==== verif/processor_vectors.txt ====
# dinA dinB F R expA expB
# hex operands, F and R as decimal codes, hex expected registers
C5 A3 0 1 C5 81
C5 A3 1 1 C5 E7
C5 A3 2 1 C5 66
C5 A3 3 1 C5 FF
C5 A3 4 1 C5 7E
C5 A3 5 1 C5 18
C5 A3 6 1 C5 99
C5 A3 7 1 C5 00
3C 96 2 2 AA 96
3C 96 0 2 14 96
3C 96 5 0 3C 96
3C 96 1 3 96 3C
F0 5A 6 1 F0 55
F0 5A 4 2 AF 5A
F0 5A 3 3 5A F0
3C 96 7 2 00 96
F0 5A 0 0 F0 5A
3C 96 6 2 55 96
96 3C 2 3 3C 96
81 7E 4 1 81 FF
A5 0F 2 2 AA 0F
00 FF 1 1 00 FF
5A 0F 5 2 A0 0F
5A 0F 0 1 5A 0A
